//--- hdl/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal geometry in pixel clocks, the line length has to stay even
`define LINE_LEN        64
`define H_ACTIVE_START  8
`define H_ACTIVE_END    48
`define H_BLANK_START   52
`define H_BLANK_END     64      // blank runs to the end of the line
`define HSYNC_START     54
`define HSYNC_LEN       6

// vertical geometry in lines, kept short so a frame is cheap to simulate
`define FRAME_LINES     40
`define V_ACTIVE_START  4
`define V_ACTIVE_END    32
`define VBLANK_START    34
`define VBLANK_END      40
`define VSYNC_START     35
`define VSYNC_LEN       2

`define COLOR_W         6       // two bits per channel
`define H_CNT_W         6       // enough for LINE_LEN counts
`define V_CNT_W         6       // enough for FRAME_LINES counts
`define BUF_DEPTH       (`LINE_LEN / 2)
`define BUF_AW          5       // log2 of BUF_DEPTH

`endif

//--- hdl/video_timing_pkg.sv
package video_timing_pkg;

	// one bundle of raster strobes, all registered and aligned to the counts
	typedef struct packed
	{
		logic hblank;           // horizontal blanking, sync included
		logic vblank;           // vertical blanking
		logic hpix;             // inside the horizontal active window
		logic vpix;             // inside the vertical active window
		logic hsync;            // tv horizontal sync
		logic vsync;            // vertical sync, shared by tv and vga
		logic vga_hsync;        // short sync at the start of each half line
		logic scanin_start;     // first clock of a tv line
		logic scanout_start;    // first clock of each vga half line
		logic hsync_start;      // first clock of the tv sync pulse
	} raster_t;

	// the horizontal sweep goes border, active, border, blank, sync, blank
	typedef enum logic [1:0]
	{
		ph_active,
		ph_border,
		ph_blank,
		ph_sync
	} raster_phase_e;

endpackage

//--- hdl/video_color_pkg.sv
`include "video_macros.svh"

package video_color_pkg;

	// pixel format used throughout, red in the top bits as the dac expects
	typedef struct packed
	{
		logic [`COLOR_W/3-1:0] red;
		logic [`COLOR_W/3-1:0] green;
		logic [`COLOR_W/3-1:0] blue;
	} color_t;

	// which layer wins the dot, in falling priority
	typedef enum logic [1:0]
	{
		src_blank,
		src_sprite,
		src_gfx,
		src_border
	} color_src_e;

	typedef struct packed
	{
		color_t color;  // registered colour toward the resistor dac
		logic   hsync;  // tv or vga horizontal sync depending on mode
		logic   vsync;
		logic   csync;  // composite sync, idles high
	} dac_t;

endpackage

//--- hdl/raster_timer.sv
`timescale 1ns/1ps
`include "video_macros.svh"

module raster_timer (
	input  logic                      clk,
	input  logic                      rst_n,
	output video_timing_pkg::raster_t raster
);
	import video_timing_pkg::*;

	logic [`H_CNT_W-1:0] hcnt;         // pixel clock within the line
	logic [`H_CNT_W-1:0] hcnt_next;
	logic [`V_CNT_W-1:0] vcnt;         // line within the frame
	logic [`V_CNT_W-1:0] vcnt_next;
	raster_phase_e       phase;        // horizontal phase of the current count
	raster_phase_e       phase_next;

	// strobes for a given position, used for both the reset and the running values
	function automatic raster_t decode(
		input logic [`H_CNT_W-1:0] h,
		input logic [`V_CNT_W-1:0] v,
		input raster_phase_e       ph
	);
		raster_t r;
		r.hblank        = (ph == ph_blank) || (ph == ph_sync);
		r.vblank        = (v >= `VBLANK_START) && (v < `VBLANK_END);
		r.hpix          = (ph == ph_active);
		r.vpix          = (v >= `V_ACTIVE_START) && (v < `V_ACTIVE_END);
		r.hsync         = (ph == ph_sync);
		r.vsync         = (v >= `VSYNC_START) && (v < `VSYNC_START + `VSYNC_LEN);
		// vga sync repeats every half line at half the tv pulse width
		r.vga_hsync     = (h % (`LINE_LEN / 2)) < (`HSYNC_LEN / 2);
		r.scanin_start  = (h == 0);
		r.scanout_start = (h == 0) || (h == `LINE_LEN / 2);
		r.hsync_start   = (h == `HSYNC_START);
		return r;
	endfunction

	always_comb
	begin
		hcnt_next = (hcnt == `LINE_LEN - 1) ? '0 : hcnt + 1'b1;
		vcnt_next = vcnt;
		if (hcnt == `LINE_LEN - 1) // the line counter only moves on the wrap
		begin
			vcnt_next = (vcnt == `FRAME_LINES - 1) ? '0 : vcnt + 1'b1;
		end
	end

	// phase steps on the count that is about to be loaded, so it lines up with hcnt
	always_comb
	begin
		phase_next = phase;
		case (phase)
			ph_border:
			begin
				if (hcnt_next == `H_ACTIVE_START)
					phase_next = ph_active;
				else if (hcnt_next == `H_BLANK_START)
					phase_next = ph_blank;
			end
			ph_active:
			begin
				if (hcnt_next == `H_ACTIVE_END)
					phase_next = ph_border; // right border follows the window
			end
			ph_blank:
			begin
				if (hcnt_next == `HSYNC_START)
					phase_next = ph_sync;
				else if (hcnt_next == (`H_BLANK_END % `LINE_LEN))
					phase_next = ph_border; // blank end may sit on the wrap
			end
			ph_sync:
			begin
				if (hcnt_next == `HSYNC_START + `HSYNC_LEN)
					phase_next = ph_blank; // back porch
			end
			default:
				phase_next = ph_border;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hcnt   <= '0;
			vcnt   <= '0;
			phase  <= ph_border; // count zero lies in the left border
			raster <= decode('0, '0, ph_border);
		end
		else
		begin
			hcnt   <= hcnt_next;
			vcnt   <= vcnt_next;
			phase  <= phase_next;
			raster <= decode(hcnt_next, vcnt_next, phase_next); // valid with the new counts
		end
	end

endmodule

//--- hdl/vga_double.sv
`timescale 1ns/1ps
`include "video_macros.svh"

module vga_double (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     scanin_start,
	input  logic                     scanout_start,
	input  logic                     hsync_start,
	input  video_color_pkg::color_t  pix_in,
	output video_color_pkg::color_t  pix_out
);
	import video_color_pkg::*;

	// both banks in one array, the bank select is the top address bit
	color_t             mem [2*`BUF_DEPTH];

	logic               wr_bank;     // bank being filled by the current tv line
	logic               armed;       // an hsync was seen since the last swap
	logic               wr_skip;     // odd clock of the half-rate capture
	logic [`BUF_AW-1:0] wr_addr;
	logic [`BUF_AW-1:0] wr_waddr;
	logic               wr_en;
	logic [`BUF_AW-1:0] rd_ptr;
	logic [`BUF_AW-1:0] rd_addr;
	logic [1:0]         bank_ok;     // bank holds a complete line since reset
	logic               swap;
	logic               bank_in;
	logic               rd_bank;

	assign swap    = scanin_start & armed;
	assign bank_in = wr_bank ^ swap;  // the swap already applies to its own clock
	assign rd_bank = ~bank_in;        // playback always uses the line finished before

	// line start writes sample zero, after that every second clock
	assign wr_en    = swap | ~wr_skip;
	assign wr_waddr = swap ? '0 : wr_addr;

	// restart lands on address zero in the same clock as scanout_start
	assign rd_addr = scanout_start ? '0 : rd_ptr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_bank <= 1'b0;
			armed   <= 1'b1; // the first line after reset is taken without a prior sync
			wr_skip <= 1'b0;
			wr_addr <= '0;
			rd_ptr  <= '0;
			bank_ok <= 2'b00;
		end
		else
		begin
			wr_bank <= bank_in;
			rd_ptr  <= rd_addr + 1'b1; // full rate, wraps back at the half line
			if (swap)
			begin
				wr_addr          <= `BUF_AW'(1);
				wr_skip          <= 1'b1;
				bank_ok[bank_in] <= 1'b1;
			end
			else
			begin
				wr_skip <= ~wr_skip;
				if (!wr_skip)
					wr_addr <= wr_addr + 1'b1;
			end
			if (hsync_start)
				armed <= 1'b1;
			else if (swap)
				armed <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[{bank_in, wr_waddr}] <= pix_in;
	end

	// black until the read bank has been written once, so no stale data leaks out
	always_ff @(posedge clk)
	begin
		pix_out <= bank_ok[rd_bank] ? mem[{rd_bank, rd_addr}] : '0;
	end

endmodule

//--- hdl/videoout.sv
`timescale 1ns/1ps

module videoout (
	input  logic                      clk,
	input  logic                      rst_n,
	input  video_timing_pkg::raster_t raster,
	input  video_color_pkg::color_t   pixel,
	input  video_color_pkg::color_t   spixel,
	input  video_color_pkg::color_t   border,
	input  logic                      spx_en,
	input  logic                      zxg_en,     // high turns the graphics layer off
	input  logic                      cfg_vga_on,
	output video_color_pkg::dac_t     dac
);
	import video_color_pkg::*;

	color_src_e src;        // winning layer for this dot
	color_t     color;      // tv rate colour
	color_t     vga_color;  // doubled colour from the line buffer

	always_comb
	begin
		if (raster.hblank || raster.vblank)
			src = src_blank;
		else if (spx_en)
			src = src_sprite; // sprites cover graphics and border alike
		else if (raster.hpix && raster.vpix && !zxg_en)
			src = src_gfx;
		else
			src = src_border;
	end

	always_comb
	begin
		case (src)
			src_sprite: color = spixel;
			src_gfx:    color = pixel;
			src_border: color = border;
			default:    color = '0;
		endcase
	end

	// the doubler always captures, so a mode change needs no warm up line
	vga_double u_vga_double (
		.clk           (clk),
		.rst_n         (rst_n),
		.scanin_start  (raster.scanin_start),
		.scanout_start (raster.scanout_start),
		.hsync_start   (raster.hsync_start),
		.pix_in        (color),
		.pix_out       (vga_color)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dac <= '{color: '0, hsync: 1'b0, vsync: 1'b0, csync: 1'b1};
		end
		else
		begin
			dac.color <= cfg_vga_on ? vga_color : color;
			dac.hsync <= cfg_vga_on ? raster.vga_hsync : raster.hsync;
			dac.vsync <= raster.vsync; // same frame timing in both modes
			// composite sync is built from the tv syncs even in vga mode
			dac.csync <= ~(raster.hsync ^ raster.vsync);
		end
	end

endmodule

//--- hdl/video_subsystem.sv
`timescale 1ns/1ps

module video_subsystem (
	input  logic                    clk,
	input  logic                    rst_n,
	input  video_color_pkg::color_t pixel,      // graphics layer
	input  video_color_pkg::color_t spixel,     // sprite layer
	input  video_color_pkg::color_t border,     // border colour register
	input  logic                    spx_en,     // sprite layer owns the dot
	input  logic                    zxg_en,
	input  logic                    cfg_vga_on, // scan doubled output
	output video_color_pkg::dac_t   dac
);
	import video_timing_pkg::*;

	raster_t raster; // strobes from the timer into the output stage

	raster_timer u_raster_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.raster (raster)
	);

	videoout u_videoout (
		.clk        (clk),
		.rst_n      (rst_n),
		.raster     (raster),
		.pixel      (pixel),
		.spixel     (spixel),
		.border     (border),
		.spx_en     (spx_en),
		.zxg_en     (zxg_en),
		.cfg_vga_on (cfg_vga_on),
		.dac        (dac)
	);

endmodule

//--- sim/video_properties.sv
`timescale 1ns/1ps

module video_properties (
	input logic                          clk,
	input logic                          rst_n,
	input video_timing_pkg::raster_t     raster,
	input logic                          cfg_vga_on,
	input video_color_pkg::color_src_e   src,        // mux decision inside videoout
	input video_color_pkg::dac_t         dac
);
	import video_color_pkg::*;

	// composite sync comes from the tv syncs of the clock before
	property csync_follows_syncs;
		@(posedge clk) disable iff (!rst_n)
			$past(rst_n) |-> dac.csync == ~($past(raster.hsync) ^ $past(raster.vsync));
	endproperty

	// vsync is the same in both modes, just one register later
	property vsync_passthrough;
		@(posedge clk) disable iff (!rst_n)
			$past(rst_n) |-> dac.vsync == $past(raster.vsync);
	endproperty

	// a blanked dot in tv mode has to reach the dac as black
	property blank_is_black;
		@(posedge clk) disable iff (!rst_n)
			(src == src_blank) && !cfg_vga_on |=> dac.color == '0;
	endproperty

	assert property (csync_follows_syncs)
		else $error("csync is not the inverted xor of the previous syncs");
	assert property (vsync_passthrough)
		else $error("dac vsync does not follow the raster vsync");
	assert property (blank_is_black)
		else $error("colour after a blanked tv cycle is not black");

endmodule

bind videoout video_properties u_video_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.raster     (raster),
	.cfg_vga_on (cfg_vga_on),
	.src        (src),
	.dac        (dac)
);

//--- sim/video_tb.sv
`timescale 1ns/1ps
`include "video_macros.svh"

module video_tb;
	import video_color_pkg::*;

	localparam int   CLK_PERIOD  = 10;
	localparam int   FRAME_CLKS  = `LINE_LEN * `FRAME_LINES;
	localparam int   TEST_FRAMES = 5;    // every test after reset runs one frame
	localparam int   MARGIN_CLKS = 200;
	localparam dac_t DAC_IDLE    = '{color: '0, hsync: 1'b0, vsync: 1'b0, csync: 1'b1};

	logic clk;
	logic rst_n;
	color_t pixel;
	color_t spixel;
	color_t border;
	logic spx_en;
	logic zxg_en;
	logic cfg_vga_on;
	dac_t dac;

	logic [31:0] seed;
	int h = 0;          // reference raster position that resets with the DUT
	int v = 0;
	int live = 0;       // checked cycles since reset release
	string test_name;
	int test_errs = 0;
	int total_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// what the previous cycle should produce on dac as captured at its falling edge
	color_t prev_color;
	logic prev_vga;
	logic prev_hsync;
	logic prev_vsync;
	logic prev_vga_hsync;
	color_t cur_line [`BUF_DEPTH];  // samples of the tv line in progress
	color_t prev_line [`BUF_DEPTH]; // last finished line which is being replayed
	color_t rd_q1;
	color_t rd_q2;
	int hits [4];
	int zxg_hits;
	int sync_rises;
	int sync_highs;
	logic last_hsync = 1'b0;
	logic count_syncs = 1'b0;

	video_subsystem u_video_subsystem (
		.clk        (clk),
		.rst_n      (rst_n),
		.pixel      (pixel),
		.spixel     (spixel),
		.border     (border),
		.spx_en     (spx_en),
		.zxg_en     (zxg_en),
		.cfg_vga_on (cfg_vga_on),
		.dac        (dac)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic in_window(input int x, input int lo, input int hi);
		return (x >= lo) && (x < hi);
	endfunction

	// priority black, sprite, graphics, border straight from the window macros
	function automatic color_src_e pick_source(input int hc, input int vc, input logic spx,
		input logic zxg);
		if (in_window(hc, `H_BLANK_START, `H_BLANK_END) ||
			in_window(vc, `VBLANK_START, `VBLANK_END))
			return src_blank;
		if (spx)
			return src_sprite;
		if (in_window(hc, `H_ACTIVE_START, `H_ACTIVE_END) && !zxg &&
			in_window(vc, `V_ACTIVE_START, `V_ACTIVE_END))
			return src_gfx;
		return src_border;
	endfunction

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("mismatch %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		test_errs++;
		total_errs++;
	endtask

	task automatic report_failure(input string msg);
		$display("error in %s: %s", test_name, msg);
		test_errs++;
		total_errs++;
	endtask

	task automatic drive_random();
		seed = lcg_next(seed);
		pixel = seed[31:26]; // upper bits since the low ones of an lcg repeat quickly
		spixel = seed[25:20];
		border = seed[19:14];
		spx_en = (seed[13:12] == 2'b00); // sprite owns about a quarter of the dots
		zxg_en = (seed[11:10] == 2'b00);
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		int i;
		test_name = name;
		test_errs = 0;
		zxg_hits = 0;
		sync_rises = 0;
		sync_highs = 0;
		for (i = 0; i < 4; i++)
			hits[i] = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, test_errs);
		end
	endtask

	task automatic run_frame(input string name, input logic vga, input logic toggle_mode);
		int i;
		start_test(name);
		cfg_vga_on = vga;
		for (i = 0; i < FRAME_CLKS; i++)
		begin
			if (toggle_mode && (i % 37 == 36))
				cfg_vga_on = ~cfg_vga_on; // drifts to a different dot every time
			drive_random();
			step();
		end
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			h <= 0;
			v <= 0;
		end
		else
		begin
			h <= (h == `LINE_LEN - 1) ? 0 : h + 1;
			if (h == `LINE_LEN - 1)
				v <= (v == `FRAME_LINES - 1) ? 0 : v + 1;
		end
	end

	// dac is stable at the falling edge and holds the result of the cycle before
	always @(negedge clk)
	begin
		color_src_e src;
		color_t cur_color;
		color_t exp_color;
		logic exp_hsync;
		logic exp_csync;
		if (rst_n)
		begin
			if (live == 0)
			begin
				assert (dac === DAC_IDLE)
					else report_mismatch("dac after reset", int'(DAC_IDLE), int'(dac));
			end
			else
			begin
				exp_color = prev_vga ? rd_q2 : prev_color;
				exp_hsync = prev_vga ? prev_vga_hsync : prev_hsync;
				exp_csync = ~(prev_hsync ^ prev_vsync);
				assert (dac.color === exp_color)
					else report_mismatch("colour", int'(exp_color), int'(dac.color));
				assert (dac.hsync === exp_hsync)
					else report_mismatch("hsync", int'(exp_hsync), int'(dac.hsync));
				assert (dac.vsync === prev_vsync)
					else report_mismatch("vsync", int'(prev_vsync), int'(dac.vsync));
				assert (dac.csync === exp_csync)
					else report_mismatch("csync", int'(exp_csync), int'(dac.csync));
			end
			assert (!$isunknown(dac)) else report_failure("dac carries an unknown value");

			src = pick_source(h, v, spx_en, zxg_en);
			case (src)
				src_sprite: cur_color = spixel;
				src_gfx:    cur_color = pixel;
				src_border: cur_color = border;
				default:    cur_color = '0;
			endcase
			hits[int'(src)]++;
			if (src == src_border && zxg_en && in_window(h, `H_ACTIVE_START, `H_ACTIVE_END) &&
				in_window(v, `V_ACTIVE_START, `V_ACTIVE_END))
				zxg_hits++; // graphics would have won without zxg_en

			// a finished line becomes the playback line when the next one starts
			if (h == 0)
				prev_line = cur_line;
			rd_q2 = rd_q1;
			rd_q1 = prev_line[h % `BUF_DEPTH]; // two clocks from here to the dac
			if (h % 2 == 0)
				cur_line[h / 2] = cur_color;

			prev_color = cur_color;
			prev_vga = cfg_vga_on;
			prev_hsync = in_window(h, `HSYNC_START, `HSYNC_START + `HSYNC_LEN);
			prev_vsync = in_window(v, `VSYNC_START, `VSYNC_START + `VSYNC_LEN);
			// first few clocks of either half of the line
			prev_vga_hsync = in_window(h, 0, `HSYNC_LEN / 2) ||
				in_window(h, `LINE_LEN / 2, `LINE_LEN / 2 + `HSYNC_LEN / 2);

			if (count_syncs && dac.hsync && !last_hsync)
				sync_rises++;
			if (count_syncs && dac.hsync)
				sync_highs++;
			last_hsync = dac.hsync;
			live++;
		end
	end

	initial
	begin
		int i;
		rst_n = 1'b0;
		pixel = '0;
		spixel = '0;
		border = '0;
		spx_en = 1'b0;
		zxg_en = 1'b0;
		cfg_vga_on = 1'b0;
		seed = 32'ha5d9_5471;
		rd_q1 = '0;
		rd_q2 = '0;
		for (i = 0; i < `BUF_DEPTH; i++)
		begin
			cur_line[i] = '0;
			prev_line[i] = '0;
		end

		start_test("reset");
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		drive_random();
		step(); // first cycle out of reset has been checked by now
		end_test();

		run_frame("tv_mux", 1'b0, 1'b0);
		assert (hits[int'(src_blank)] > 0) else report_failure("no dot was blanked");
		assert (hits[int'(src_sprite)] > 0) else report_failure("sprite layer never won");
		assert (hits[int'(src_gfx)] > 0) else report_failure("graphics layer never won");
		assert (hits[int'(src_border)] > 0) else report_failure("border never won");
		assert (zxg_hits > 0) else report_failure("zxg_en never hid an active dot");
		end_test();

		run_frame("tv_sync", 1'b0, 1'b0);
		end_test();

		run_frame("scan_double", 1'b1, 1'b0);
		end_test();

		count_syncs = 1'b1; // over a whole frame every line adds two pulses
		run_frame("vga_sync", 1'b1, 1'b0);
		count_syncs = 1'b0;
		assert (sync_rises == 2 * `FRAME_LINES)
			else report_mismatch("hsync pulses", 2 * `FRAME_LINES, sync_rises);
		assert (sync_highs == `FRAME_LINES * `HSYNC_LEN)
			else report_mismatch("hsync high clocks", `FRAME_LINES * `HSYNC_LEN, sync_highs);
		end_test();

		run_frame("mode_switch", 1'b1, 1'b1);
		end_test();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
		if (tests_failed == 0 && total_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// bound from the frame count of all tests plus a little for reset
	initial
	begin
		#(CLK_PERIOD * (FRAME_CLKS * TEST_FRAMES + MARGIN_CLKS));
		$display("timeout: tests did not finish within %0d frames", TEST_FRAMES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- project.f
+incdir+hdl
hdl/video_timing_pkg.sv
hdl/video_color_pkg.sv
hdl/raster_timer.sv
hdl/vga_double.sv
hdl/videoout.sv
hdl/video_subsystem.sv
sim/video_properties.sv
sim/video_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+1000
TOP       := video_tb
FILELIST  := project.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

run: $(SIM_BIN)
	$(SIM_BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
